// ==== design/dma_defines.svh ====
`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// ========================================
// Bus widths
// ========================================
`define DMA_S_ADDR_W 5                      // Register port covers 8 words
`define DMA_S_DATA_W 32
`define DMA_M_ADDR_W 64                     // Full 64-bit host address on the master side

// ========================================
// Burst geometry
// ========================================
// A burst may not cross a 4 KiB boundary, so one block is the largest burst there is
`define DMA_BLOCK_BYTES     4096
`define DMA_BEAT_BYTES      64              // 512-bit read data bus
`define DMA_BEATS_PER_BURST (`DMA_BLOCK_BYTES / `DMA_BEAT_BYTES)

// ========================================
// Register map, as word indices
// ========================================
`define DMA_REG_SRC_H    3'd0               // Upper half of the source address
`define DMA_REG_SRC_L    3'd1               // Lower half of the source address
`define DMA_REG_COUNT    3'd2               // Number of 4 KiB blocks to fetch
`define DMA_REG_CTL_STAT 3'd3               // Write starts a run, read gives busy and error

// Read data for an offset that decodes to nothing
`define DMA_BAD_REG_DATA 32'h0DEC0DE0

`endif

// ==== design/axil_pkg.sv ====
`include "dma_defines.svh"

package axil_pkg;

    // Response codes on the register port and on the read master
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // Word index taken from the byte address, low two bits dropped
    typedef logic [`DMA_S_ADDR_W-3:0] reg_index_t;

    // One register access as handed from the bus port to the register file
    typedef struct packed {
        logic                     write;    // High for a write, low for a read
        reg_index_t               index;
        logic [`DMA_S_DATA_W-1:0] wdata;    // Only meaningful on writes
    } reg_access_t;

    // Answer of the register file to one access
    typedef struct packed {
        logic [`DMA_S_DATA_W-1:0] rdata;
        axil_resp_t               resp;
    } reg_reply_t;

endpackage

// ==== design/dma_pkg.sv ====
`include "dma_defines.svh"

package dma_pkg;

    // Byte address on the AXI4 read master
    typedef logic [`DMA_M_ADDR_W-1:0] m_addr_t;

    // Everything the engine needs for one run, latched when the run starts
    typedef struct packed {
        m_addr_t                  src;      // Address of the first block
        logic [`DMA_S_DATA_W-1:0] count;    // Blocks to fetch, zero means nothing to do
    } dma_cmd_t;

    // Error sits above busy so the struct lines up with the CTL_STAT read layout
    typedef struct packed {
        logic error;                        // Sticky until the next start
        logic busy;
    } dma_status_t;

endpackage

// ==== design/axil_slave_port.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module axil_slave_port (
    input  logic                     AXI_ACLK,
    input  logic                     AXI_ARESETN,
    input  logic [`DMA_S_ADDR_W-1:0] s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,
    input  logic [`DMA_S_DATA_W-1:0] s_axi_wdata,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,
    output axil_pkg::axil_resp_t     s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,
    input  logic [`DMA_S_ADDR_W-1:0] s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    output logic [`DMA_S_DATA_W-1:0] s_axi_rdata,
    output axil_pkg::axil_resp_t     s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,
    output axil_pkg::reg_access_t    access,
    output logic                     access_start,
    input  axil_pkg::reg_reply_t     reply,
    input  logic                     reply_done
);
    import axil_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_RESP} state_t;

    state_t                   state;
    logic                     cur_read;     // Access in flight came from the read channel
    logic                     ar_full;      // A read address is held
    logic                     aw_full;      // A write address is held
    logic                     w_full;       // Write data is held
    reg_index_t               ar_index;
    reg_index_t               aw_index;
    logic [`DMA_S_DATA_W-1:0] w_data;
    reg_reply_t               reply_q;      // Held until the master takes R or B

    logic ar_hs;
    logic aw_hs;
    logic w_hs;
    logic r_hs;
    logic b_hs;

    assign ar_hs = s_axi_arvalid & s_axi_arready;
    assign aw_hs = s_axi_awvalid & s_axi_awready;
    assign w_hs  = s_axi_wvalid & s_axi_wready;
    assign r_hs  = s_axi_rvalid & s_axi_rready;
    assign b_hs  = s_axi_bvalid & s_axi_bready;

    // Each channel is ready exactly while its holding slot is empty
    assign s_axi_arready = ~ar_full;
    assign s_axi_awready = ~aw_full;
    assign s_axi_wready  = ~w_full;

    // Reads and writes are serialized, so one reply register serves both channels
    assign s_axi_rdata = reply_q.rdata;
    assign s_axi_rresp = reply_q.resp;
    assign s_axi_bresp = reply_q.resp;

    // ========================================
    // Address, data and reply capture
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (ar_hs) begin
            ar_index <= s_axi_araddr[`DMA_S_ADDR_W-1:2];    // Byte address to word index
        end
        if (aw_hs) begin
            aw_index <= s_axi_awaddr[`DMA_S_ADDR_W-1:2];
        end
        if (w_hs) begin
            w_data <= s_axi_wdata;
        end
        // Access is built in the same edge that raises access_start
        if (state == ST_IDLE) begin
            if (ar_full) begin
                access <= '{write: 1'b0, index: ar_index, wdata: w_data};
            end else begin
                access <= '{write: 1'b1, index: aw_index, wdata: w_data};
            end
        end
        if (state == ST_WAIT && reply_done) begin
            reply_q <= reply;
        end
    end

    // ========================================
    // Channel control FSM
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            state        <= ST_IDLE;
            cur_read     <= 1'b0;
            ar_full      <= 1'b0;
            aw_full      <= 1'b0;
            w_full       <= 1'b0;
            access_start <= 1'b0;
            s_axi_rvalid <= 1'b0;
            s_axi_bvalid <= 1'b0;
        end else begin
            access_start <= 1'b0;                           // One-cycle pulse
            if (ar_hs) ar_full <= 1'b1;
            if (aw_hs) aw_full <= 1'b1;                     // AW and W may land in either order
            if (w_hs)  w_full  <= 1'b1;

            case (state)
                // A pending read always wins over a complete write
                ST_IDLE: if (ar_full || (aw_full && w_full)) begin
                    access_start <= 1'b1;
                    cur_read     <= ar_full;
                    state        <= ST_WAIT;
                end

                // Register file answers one cycle after access_start
                ST_WAIT: if (reply_done) begin
                    s_axi_rvalid <= cur_read;
                    s_axi_bvalid <= ~cur_read;
                    state        <= ST_RESP;
                end

                ST_RESP: if (r_hs) begin
                    s_axi_rvalid <= 1'b0;
                    ar_full      <= 1'b0;                   // ARREADY rises again
                    state        <= ST_IDLE;
                end else if (b_hs) begin
                    s_axi_bvalid <= 1'b0;
                    aw_full      <= 1'b0;
                    w_full       <= 1'b0;
                    state        <= ST_IDLE;
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/dma_regs.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_regs (
    input  logic                  AXI_ACLK,
    input  logic                  AXI_ARESETN,
    input  axil_pkg::reg_access_t access,
    input  logic                  access_start,
    output axil_pkg::reg_reply_t  reply,
    output logic                  reply_done,
    output dma_pkg::dma_cmd_t     cmd,
    output logic                  start,
    input  dma_pkg::dma_status_t  status
);
    import axil_pkg::*;

    logic [`DMA_S_DATA_W-1:0] rd_data;
    axil_resp_t               rd_resp;

    // ========================================
    // Offset decode
    // ========================================
    // Writes go through the same decode so they pick up the right response
    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        case (access.index)
            `DMA_REG_SRC_H:    rd_data = cmd.src[`DMA_M_ADDR_W-1:`DMA_S_DATA_W];
            `DMA_REG_SRC_L:    rd_data = cmd.src[`DMA_S_DATA_W-1:0];
            `DMA_REG_COUNT:    rd_data = cmd.count;
            `DMA_REG_CTL_STAT: begin
                rd_data = {{(`DMA_S_DATA_W-$bits(status)){1'b0}}, status};
                // Engine is mid-run, so a new start is refused
                if (access.write && status.busy) begin
                    rd_resp = SLVERR;
                end
            end
            default: begin
                rd_data = `DMA_BAD_REG_DATA;
                rd_resp = SLVERR;
            end
        endcase
    end

    // ========================================
    // Register storage and start control
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            cmd        <= '0;
            start      <= 1'b0;
            reply_done <= 1'b0;
        end else begin
            reply_done <= access_start;                     // Always exactly one cycle later
            start      <= 1'b0;
            if (access_start && access.write) begin
                case (access.index)
                    `DMA_REG_SRC_H:    cmd.src[`DMA_M_ADDR_W-1:`DMA_S_DATA_W] <= access.wdata;
                    `DMA_REG_SRC_L:    cmd.src[`DMA_S_DATA_W-1:0] <= access.wdata;
                    `DMA_REG_COUNT:    cmd.count <= access.wdata;
                    `DMA_REG_CTL_STAT: start <= ~status.busy;    // Data value is ignored
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge AXI_ACLK) begin
        if (access_start) begin
            reply <= '{rdata: rd_data, resp: rd_resp};
        end
    end

endmodule

// ==== design/dma_read_engine.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module dma_read_engine (
    input  logic                 AXI_ACLK,
    input  logic                 AXI_ARESETN,
    input  dma_pkg::dma_cmd_t    cmd,
    input  logic                 start,
    output dma_pkg::dma_status_t status,
    output dma_pkg::m_addr_t     m_axi_araddr,
    output logic                 m_axi_arvalid,
    input  logic                 m_axi_arready,
    input  logic                 m_axi_rvalid,
    input  axil_pkg::axil_resp_t m_axi_rresp,
    input  logic                 m_axi_rlast,
    output logic                 m_axi_rready
);
    import axil_pkg::*;
    import dma_pkg::*;

    localparam m_addr_t BLOCK_STEP = m_addr_t'(`DMA_BLOCK_BYTES);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} state_t;

    state_t                   state;
    logic [`DMA_S_DATA_W-1:0] blocks_left;  // Includes the burst in flight
    logic                     beat_hs;
    logic                     last_hs;

    assign beat_hs = m_axi_rvalid & m_axi_rready;
    assign last_hs = beat_hs & m_axi_rlast;     // End of the current burst

    // ========================================
    // Burst sequencer
    // ========================================
    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_ARESETN) begin
            state         <= ST_IDLE;
            m_axi_arvalid <= 1'b0;
            m_axi_rready  <= 1'b0;
            status        <= '0;
        end else begin
            case (state)
                ST_IDLE: if (start) begin
                    status.error <= 1'b0;                   // Error is per run
                    // A zero count is accepted but moves nothing
                    if (cmd.count != '0) begin
                        m_axi_arvalid <= 1'b1;
                        status.busy   <= 1'b1;
                        state         <= ST_ADDR;
                    end
                end

                // ARVALID holds until the interconnect takes the address
                ST_ADDR: if (m_axi_arready) begin
                    m_axi_arvalid <= 1'b0;
                    m_axi_rready  <= 1'b1;
                    state         <= ST_DATA;
                end

                // Read data itself is discarded and only the response is watched
                ST_DATA: begin
                    if (beat_hs && m_axi_rresp != OKAY) begin
                        status.error <= 1'b1;
                    end
                    if (last_hs) begin
                        m_axi_rready <= 1'b0;
                        if (blocks_left == 1) begin
                            status.busy <= 1'b0;
                            state       <= ST_IDLE;
                        end else begin
                            m_axi_arvalid <= 1'b1;          // Next burst right after RLAST
                            state         <= ST_ADDR;
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Command is latched at start, so later register writes wait for the next run
    always_ff @(posedge AXI_ACLK) begin
        if (state == ST_IDLE && start) begin
            m_axi_araddr <= cmd.src;
            blocks_left  <= cmd.count;
        end else if (state == ST_DATA && last_hs) begin
            m_axi_araddr <= m_axi_araddr + BLOCK_STEP;
            blocks_left  <= blocks_left - 1;
        end
    end

endmodule

// ==== design/h2c_dma.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module h2c_dma (
    input  logic                     AXI_ACLK,
    input  logic                     AXI_ARESETN,
    // ========================================
    // AXI4-Lite register port
    // ========================================
    input  logic [`DMA_S_ADDR_W-1:0] s_axi_awaddr,
    input  logic                     s_axi_awvalid,
    output logic                     s_axi_awready,
    input  logic [`DMA_S_DATA_W-1:0] s_axi_wdata,
    input  logic                     s_axi_wvalid,
    output logic                     s_axi_wready,
    output axil_pkg::axil_resp_t     s_axi_bresp,
    output logic                     s_axi_bvalid,
    input  logic                     s_axi_bready,
    input  logic [`DMA_S_ADDR_W-1:0] s_axi_araddr,
    input  logic                     s_axi_arvalid,
    output logic                     s_axi_arready,
    output logic [`DMA_S_DATA_W-1:0] s_axi_rdata,
    output axil_pkg::axil_resp_t     s_axi_rresp,
    output logic                     s_axi_rvalid,
    input  logic                     s_axi_rready,
    // ========================================
    // AXI4 read master, sidebands tied outside
    // ========================================
    output dma_pkg::m_addr_t         m_axi_araddr,
    output logic                     m_axi_arvalid,
    input  logic                     m_axi_arready,
    input  logic                     m_axi_rvalid,
    input  axil_pkg::axil_resp_t     m_axi_rresp,
    input  logic                     m_axi_rlast,
    output logic                     m_axi_rready
);
    import axil_pkg::*;
    import dma_pkg::*;

    reg_access_t access;                    // Port to register file
    logic        access_start;
    reg_reply_t  reply;
    logic        reply_done;
    dma_cmd_t    cmd;                       // Register file to engine
    logic        start;
    dma_status_t status;

    axil_slave_port i_slave_port (
        .AXI_ACLK      (AXI_ACLK),
        .AXI_ARESETN   (AXI_ARESETN),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .access        (access),
        .access_start  (access_start),
        .reply         (reply),
        .reply_done    (reply_done)
    );

    dma_regs i_regs (
        .AXI_ACLK     (AXI_ACLK),
        .AXI_ARESETN  (AXI_ARESETN),
        .access       (access),
        .access_start (access_start),
        .reply        (reply),
        .reply_done   (reply_done),
        .cmd          (cmd),
        .start        (start),
        .status       (status)
    );

    dma_read_engine i_engine (
        .AXI_ACLK      (AXI_ACLK),
        .AXI_ARESETN   (AXI_ARESETN),
        .cmd           (cmd),
        .start         (start),
        .status        (status),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rresp   (m_axi_rresp),
        .m_axi_rlast   (m_axi_rlast),
        .m_axi_rready  (m_axi_rready)
    );

endmodule

// ==== testbench/tb_axi_read_responder.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module tb_axi_read_responder #(
    parameter int unsigned SEED = 32'h26009a94
) (
    input  logic                 AXI_ACLK,
    input  logic                 AXI_ARESETN,
    input  dma_pkg::m_addr_t     araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    output axil_pkg::axil_resp_t rresp,
    output logic                 rlast,
    input  logic                 rready,
    input  int                   err_burst      // Burst of the run with one SLVERR beat
);
    import axil_pkg::*;
    import dma_pkg::*;

    localparam int BEATS = `DMA_BEATS_PER_BURST;

    m_addr_t addr_q [$];                        // Accepted ARADDR values, emptied before each run

    // ========================================
    // Address accept and beat generation
    // ========================================
    initial begin : serve
        int unsigned delay;
        int          beat;
        int          burst;
        void'($urandom(SEED));                  // Seeded once, all later draws follow from it
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rresp   <= OKAY;
        rlast   <= 1'b0;
        forever begin
            @(posedge AXI_ACLK);
            if (AXI_ARESETN && arvalid) begin
                delay = $urandom_range(3, 0);   // ARREADY comes 0 to 3 cycles late
                repeat (delay) @(posedge AXI_ACLK);
                arready <= 1'b1;
                @(posedge AXI_ACLK);            // ARVALID still holds, so this edge takes it
                arready <= 1'b0;
                addr_q.push_back(araddr);
                burst = addr_q.size() - 1;
                beat  = 0;
                // Beats go out with random gaps until RLAST is taken
                while (beat < BEATS) begin
                    rvalid <= ($urandom_range(3, 0) != 0);
                    rresp  <= (burst == err_burst && beat == BEATS / 2) ? SLVERR : OKAY;
                    rlast  <= (beat == BEATS - 1);
                    @(posedge AXI_ACLK);
                    if (rvalid && rready) beat++;
                end
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_h2c_dma.sv ====
`timescale 1ns/1ps
`include "dma_defines.svh"

module tb_h2c_dma;
    import axil_pkg::*;
    import dma_pkg::*;

    localparam int WAIT_LIMIT = 100;            // Cycles allowed for one handshake
    localparam int POLL_LIMIT = 500;            // CTL_STAT reads allowed before giving up
    localparam int RUN_COUNT  = 5;

    // One row of the run table
    typedef struct packed {
        m_addr_t                  src;
        logic [`DMA_S_DATA_W-1:0] count;
        int                       err_burst;    // -1 when every beat returns OKAY
    } run_entry_t;

    logic                     AXI_ACLK;
    logic                     AXI_ARESETN;
    logic [`DMA_S_ADDR_W-1:0] s_axi_awaddr;
    logic                     s_axi_awvalid;
    logic                     s_axi_awready;
    logic [`DMA_S_DATA_W-1:0] s_axi_wdata;
    logic                     s_axi_wvalid;
    logic                     s_axi_wready;
    axil_resp_t               s_axi_bresp;
    logic                     s_axi_bvalid;
    logic                     s_axi_bready;
    logic [`DMA_S_ADDR_W-1:0] s_axi_araddr;
    logic                     s_axi_arvalid;
    logic                     s_axi_arready;
    logic [`DMA_S_DATA_W-1:0] s_axi_rdata;
    axil_resp_t               s_axi_rresp;
    logic                     s_axi_rvalid;
    logic                     s_axi_rready;
    m_addr_t                  m_axi_araddr;
    logic                     m_axi_arvalid;
    logic                     m_axi_arready;
    logic                     m_axi_rvalid;
    axil_resp_t               m_axi_rresp;
    logic                     m_axi_rlast;
    logic                     m_axi_rready;
    int                       err_burst;
    run_entry_t               runs [RUN_COUNT];

    h2c_dma i_dut (.*);

    tb_axi_read_responder #(.SEED(32'h26009a94)) i_resp (
        .AXI_ACLK    (AXI_ACLK),
        .AXI_ARESETN (AXI_ARESETN),
        .araddr      (m_axi_araddr),
        .arvalid     (m_axi_arvalid),
        .arready     (m_axi_arready),
        .rvalid      (m_axi_rvalid),
        .rresp       (m_axi_rresp),
        .rlast       (m_axi_rlast),
        .rready      (m_axi_rready),
        .err_burst   (err_burst)
    );

    initial begin
        AXI_ACLK = 1'b0;
        forever #10 AXI_ACLK = ~AXI_ACLK;       // 20 ns period
    end

    // ========================================
    // Failure handling and compare tasks
    // ========================================
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [`DMA_S_DATA_W-1:0] got,
                              input logic [`DMA_S_DATA_W-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input m_addr_t got, input m_addr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input dma_status_t got,
                                input dma_status_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
        end
    endtask

    // ========================================
    // Register port access
    // ========================================
    function automatic logic [`DMA_S_ADDR_W-1:0] reg_addr(input reg_index_t idx);
        return {idx, 2'b00};                    // Word index back to a byte offset
    endfunction

    // AW and W go out together, BREADY stays high so B completes on the edge it is seen
    task automatic reg_write(input logic [`DMA_S_ADDR_W-1:0] addr,
                             input logic [`DMA_S_DATA_W-1:0] data, input axil_resp_t exp);
        logic aw_done;
        logic w_done;
        int   cycles;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cycles  = 0;
        @(posedge AXI_ACLK);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(posedge AXI_ACLK);
            if (s_axi_awvalid && s_axi_awready) begin
                aw_done = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_done = 1'b1;
                s_axi_wvalid <= 1'b0;
            end
            cycles++;
            if (cycles > WAIT_LIMIT) stop_with_failure("Write address or data never accepted");
        end
        cycles = 0;
        do begin
            @(posedge AXI_ACLK);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_with_failure("Write response never arrived");
        end while (!s_axi_bvalid);
        check_resp("s_axi_bresp", s_axi_bresp, exp);
    endtask

    task automatic reg_read(input logic [`DMA_S_ADDR_W-1:0] addr, input axil_resp_t exp,
                            output logic [`DMA_S_DATA_W-1:0] data);
        int cycles;
        cycles = 0;
        @(posedge AXI_ACLK);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do begin
            @(posedge AXI_ACLK);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_with_failure("Read address never accepted");
        end while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        cycles = 0;
        do begin
            @(posedge AXI_ACLK);
            cycles++;
            if (cycles > WAIT_LIMIT) stop_with_failure("Read data never arrived");
        end while (!s_axi_rvalid);
        data = s_axi_rdata;
        check_resp("s_axi_rresp", s_axi_rresp, exp);
    endtask

    // ========================================
    // Stimulus
    // ========================================
    initial begin : main_seq
        logic [`DMA_S_DATA_W-1:0] rd;
        dma_status_t              exp_st;
        int                       polls;
        // Entry 2 carries into the upper half, entry 3 is an empty run
        runs = '{'{src: 64'h0000_0001_2340_0000, count: 32'd3, err_burst: -1},
                 '{src: 64'h0000_00A0_0000_0000, count: 32'd2, err_burst: 1},
                 '{src: 64'h8000_0000_FFFF_F000, count: 32'd2, err_burst: -1},
                 '{src: 64'h0000_0000_0000_5000, count: 32'd0, err_burst: -1},
                 '{src: 64'h1234_5678_9ABC_0000, count: 32'd1, err_burst: 0}};
        AXI_ARESETN   <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_awvalid <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        s_axi_araddr  <= '0;
        s_axi_arvalid <= 1'b0;
        s_axi_rready  <= 1'b1;
        err_burst     = -1;
        repeat (3) @(posedge AXI_ACLK);
        AXI_ARESETN <= 1'b1;

        // Offset 0x10 decodes to no register
        reg_write(5'h10, 32'hFFFF_FFFF, SLVERR);
        reg_read(5'h10, SLVERR, rd);
        check_data("s_axi_rdata", rd, 32'h0DEC0DE0);

        for (int i = 0; i < RUN_COUNT; i++) begin
            err_burst = runs[i].err_burst;
            i_resp.addr_q.delete();
            reg_write(reg_addr(`DMA_REG_SRC_H), runs[i].src[63:32], OKAY);
            reg_write(reg_addr(`DMA_REG_SRC_L), runs[i].src[31:0], OKAY);
            reg_write(reg_addr(`DMA_REG_COUNT), runs[i].count, OKAY);
            reg_read(reg_addr(`DMA_REG_SRC_H), OKAY, rd);
            check_data("s_axi_rdata", rd, runs[i].src[63:32]);
            reg_read(reg_addr(`DMA_REG_SRC_L), OKAY, rd);
            check_data("s_axi_rdata", rd, runs[i].src[31:0]);
            reg_read(reg_addr(`DMA_REG_COUNT), OKAY, rd);
            check_data("s_axi_rdata", rd, runs[i].count);

            reg_write(reg_addr(`DMA_REG_CTL_STAT), 32'h1, OKAY);
            if (runs[i].count != 0) begin
                // Engine is mid-run here, the second start is refused
                reg_write(reg_addr(`DMA_REG_CTL_STAT), 32'h1, SLVERR);
                reg_write(reg_addr(`DMA_REG_COUNT), runs[i].count + 32'd5, OKAY);
            end

            polls = 0;
            do begin
                reg_read(reg_addr(`DMA_REG_CTL_STAT), OKAY, rd);
                polls++;
                if (polls > POLL_LIMIT) stop_with_failure("Busy bit never cleared");
            end while (rd[0]);
            exp_st = '{error: (runs[i].err_burst != -1), busy: 1'b0};
            check_status("status", dma_status_t'(rd[1:0]), exp_st);
            check_data("s_axi_rdata", rd, {30'd0, exp_st.error, 1'b0});  // Bit 1 error, bit 0 busy

            // One burst per block, 4 KiB apart, in order
            check_data("AR handshake count", i_resp.addr_q.size(), runs[i].count);
            for (int k = 0; k < i_resp.addr_q.size(); k++) begin
                check_addr("m_axi_araddr", i_resp.addr_q[k],
                           runs[i].src + m_addr_t'(k) * m_addr_t'(`DMA_BLOCK_BYTES));
            end
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+design
design/axil_pkg.sv
design/dma_pkg.sv
design/axil_slave_port.sv
design/dma_regs.sv
design/dma_read_engine.sv
design/h2c_dma.sv
testbench/tb_axi_read_responder.sv
testbench/tb_h2c_dma.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a non-zero exit
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f project.f --top-module tb_h2c_dma -o tb_h2c_dma
./obj_dir/tb_h2c_dma
